//--- spi_flash_rd.f
verilog/spi_flash_pkg.sv
verilog/spi_cfg_reg.sv
verilog/spi_cmd_seq.sv
verilog/spi_byte_shifter.sv
verilog/spi_word_assembler.sv
verilog/spi_flash_rd.sv
sim/flash_model.sv
sim/spi_flash_rd_sva.sv
sim/tb_spi_flash_rd.sv

//--- Makefile
TOP := tb_spi_flash_rd

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f spi_flash_rd.f -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

//--- sim/tb_spi_flash_rd.sv
`timescale 1ns/100ps

module tb_spi_flash_rd;
    import spi_flash_pkg::*;

    localparam int CLK_PERIOD       = 20;
    localparam int DRIVE_DELAY      = 2;
    localparam int RESET_CYCLES     = 10;
    localparam int CYCLES_PER_ENTRY = 200;
    localparam int N_ENTRIES        = 20;

    localparam flash_addr_t SEQ_BASE  = 24'h000100;
    localparam flash_addr_t JUMP_ADDR = 24'h0020C0;
    localparam flash_addr_t WAKE_ADDR = 24'h003F10;

    localparam word_t BITBANG_WDATA  = 32'h0000_0A25;    // en 0, oe a, csb 1, clk 0, do 5
    localparam word_t BITBANG_RDATA  = 32'h0000_0A20;    // low nibble is the idle flash output
    localparam word_t REENABLE_WDATA = 32'h8000_0000;
    localparam word_t REENABLE_RDATA = 32'h8000_0020;

    typedef enum logic [2:0] {
        OP_READ,
        OP_MARK,
        OP_READ_CMDS,
        OP_WAKE_CMDS,
        OP_CFG_WR
    } op_t;

    typedef struct packed {
        op_t   op;
        word_t arg;
        word_t exp;
    } entry_t;

    logic        clk;
    logic        resetn;
    logic        valid;
    flash_addr_t addr;
    logic        ready;
    word_t       rdata;
    lane_t       cfg_we;
    word_t       cfg_wdata;
    word_t       cfg_rdata;
    logic        flash_csb;
    logic        flash_clk;
    lane_t       flash_oe;
    lane_t       flash_do;
    lane_t       flash_di;
    logic        flash_so;
    entry_t      stim [N_ENTRIES];
    int          seed = 32'h95f3;

    assign flash_di = {2'b00, flash_so, 1'b0};    // flash answers on io1

    spi_flash_rd u_spi_flash_rd (
        .clk         (clk),
        .resetn      (resetn),
        .valid_i     (valid),
        .addr_i      (addr),
        .ready_o     (ready),
        .rdata_o     (rdata),
        .cfg_we_i    (cfg_we),
        .cfg_wdata_i (cfg_wdata),
        .cfg_rdata_o (cfg_rdata),
        .flash_csb_o (flash_csb),
        .flash_clk_o (flash_clk),
        .flash_oe_o  (flash_oe),
        .flash_do_o  (flash_do),
        .flash_di_i  (flash_di)
    );

    flash_model u_flash (
        .csb_i (flash_csb),
        .sck_i (flash_clk),
        .si_i  (flash_do[0]),
        .so_o  (flash_so)
    );

    bind spi_flash_rd spi_flash_rd_sva u_sva (
        .clk            (clk),
        .resetn         (resetn),
        .ready_i        (ready_o),
        .rdata_i        (rdata_o),
        .cfg_rdata_i    (cfg_rdata_o),
        .flash_csb_i    (flash_csb_o),
        .flash_clk_i    (flash_clk_o),
        .byte_valid_i   (byte_valid),
        .byte_ready_i   (byte_ready),
        .byte_data_i    (byte_data),
        .byte_tag_i     (byte_tag),
        .jump_i         (jump),
        .soft_restart_i (soft_restart)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        repeat (RESET_CYCLES + N_ENTRIES * CYCLES_PER_ENTRY) @(posedge clk);
        $display("watchdog expired before the stimulus table finished");
        $display("TESTS FAILED");
        $fatal(1, "timeout");
    end

    function automatic word_t flash_word(flash_addr_t a);
        word_t       w;
        flash_addr_t b;
        for (int i = 0; i < 4; i++) begin
            b = a + flash_addr_t'(i);
            w[8*i +: 8] = b[7:0] ^ b[15:8] ^ 8'h5A;    // lowest address in the low byte
        end
        return w;
    endfunction

    function automatic word_t pack_pins(lane_t oe, logic csb, logic sck, lane_t dout);
        word_t w;
        w = '0;
        w[CFG_OE_LSB +: 4] = oe;
        w[CFG_CSB_BIT]     = csb;
        w[CFG_CLK_BIT]     = sck;
        w[CFG_DO_LSB +: 4] = dout;
        return w;
    endfunction

    function automatic entry_t make_entry(op_t op, word_t arg, word_t exp);
        entry_t e;
        e.op  = op;
        e.arg = arg;
        e.exp = exp;
        return e;
    endfunction

    task automatic report_failure(string line);
        $display("%s", line);
        $display("TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            report_failure($sformatf("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp));
        end
    endtask

    task automatic check_cfg(string name, word_t got, word_t exp);
        if (got !== exp) begin
            report_failure($sformatf("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp));
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            report_failure($sformatf("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic check_count(string name, int got, int exp);
        if (got != exp) begin
            report_failure($sformatf("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic check_addr(string name, flash_addr_t got, flash_addr_t exp);
        if (got !== exp) begin
            report_failure($sformatf("[FAIL] %s got 0x%06h expected 0x%06h", name, got, exp));
        end
    endtask

    task automatic read_word(flash_addr_t a, word_t exp);
        @(posedge clk);
        #DRIVE_DELAY;
        valid = 1'b1;
        addr  = a;
        @(negedge clk);
        while (!ready) begin
            @(negedge clk);
        end
        check_word("rdata_o", rdata, exp);
        @(posedge clk);
        #DRIVE_DELAY;
        valid = 1'b0;
    endtask

    task automatic write_cfg(word_t wdata, word_t exp_rdata);
        @(posedge clk);
        #DRIVE_DELAY;
        cfg_we    = 4'hF;
        cfg_wdata = wdata;
        @(posedge clk);
        #DRIVE_DELAY;
        cfg_we = '0;
        @(negedge clk);
        check_cfg("cfg_rdata_o", cfg_rdata, exp_rdata);
        if (!wdata[CFG_EN_BIT]) begin
            check_cfg("flash pins", pack_pins(flash_oe, flash_csb, flash_clk, flash_do),
                      pack_pins(wdata[CFG_OE_LSB +: 4], wdata[CFG_CSB_BIT],
                                wdata[CFG_CLK_BIT], wdata[CFG_DO_LSB +: 4]));
        end
    endtask

    task automatic build_stimulus();
        flash_addr_t a;
        for (int i = 0; i < 4; i++) begin
            a = flash_addr_t'($random(seed));
            a = {a[23:2], 2'b00};
            stim[i] = make_entry(OP_READ, word_t'(a), flash_word(a));
        end
        stim[4]  = make_entry(OP_MARK, '0, '0);
        stim[5]  = make_entry(OP_READ, word_t'(SEQ_BASE), flash_word(SEQ_BASE));
        stim[6]  = make_entry(OP_READ, word_t'(SEQ_BASE + 24'd4), flash_word(SEQ_BASE + 24'd4));
        stim[7]  = make_entry(OP_READ, word_t'(SEQ_BASE + 24'd8), flash_word(SEQ_BASE + 24'd8));
        stim[8]  = make_entry(OP_READ_CMDS, word_t'(SEQ_BASE), 32'd1);    // one command for all three
        stim[9]  = make_entry(OP_MARK, '0, '0);
        stim[10] = make_entry(OP_READ, word_t'(JUMP_ADDR), flash_word(JUMP_ADDR));
        stim[11] = make_entry(OP_READ_CMDS, word_t'(JUMP_ADDR), 32'd1);
        stim[12] = make_entry(OP_MARK, '0, '0);
        stim[13] = make_entry(OP_CFG_WR, BITBANG_WDATA, BITBANG_RDATA);
        stim[14] = make_entry(OP_CFG_WR, REENABLE_WDATA, REENABLE_RDATA);
        stim[15] = make_entry(OP_READ, word_t'(WAKE_ADDR), flash_word(WAKE_ADDR));
        stim[16] = make_entry(OP_WAKE_CMDS, '0, 32'd1);
        stim[17] = make_entry(OP_READ_CMDS, word_t'(WAKE_ADDR), 32'd1);
        a = flash_addr_t'($random(seed));
        a = {a[23:2], 2'b00};
        stim[18] = make_entry(OP_READ, word_t'(a), flash_word(a));
        stim[19] = make_entry(OP_READ, word_t'(a + 24'd4), flash_word(a + 24'd4));
    endtask

    initial begin
        int reads_mark;
        int wakes_mark;
        reads_mark = 0;
        wakes_mark = 0;
        resetn    = 1'b0;
        valid     = 1'b0;
        addr      = '0;
        cfg_we    = '0;
        cfg_wdata = '0;
        build_stimulus();
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        resetn = 1'b1;
        @(negedge clk);
        check_bit("flash_csb_o", flash_csb, 1'b1);
        check_bit("ready_o", ready, 1'b0);
        check_cfg("cfg_rdata_o", cfg_rdata, CFG_RESET | (word_t'(1) << CFG_CSB_BIT));
        for (int i = 0; i < N_ENTRIES; i++) begin
            case (stim[i].op)
                OP_READ: begin
                    read_word(stim[i].arg[23:0], stim[i].exp);
                end
                OP_MARK: begin
                    reads_mark = u_flash.read_count;
                    wakes_mark = u_flash.wake_count;
                end
                OP_READ_CMDS: begin
                    check_count("read commands", u_flash.read_count - reads_mark,
                                int'(stim[i].exp));
                    check_addr("read command address", u_flash.last_read_addr,
                               stim[i].arg[23:0]);
                end
                OP_WAKE_CMDS: begin
                    check_count("wake commands", u_flash.wake_count - wakes_mark,
                                int'(stim[i].exp));
                end
                default: begin
                    write_cfg(stim[i].arg, stim[i].exp);
                end
            endcase
        end
        if (u_spi_flash_rd.u_sva.fail_count != 0) begin
            report_failure("a bound protocol assertion failed during the run");
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

//--- sim/spi_flash_rd_sva.sv
`timescale 1ns/100ps

module spi_flash_rd_sva (
    input logic                     clk,
    input logic                     resetn,
    input logic                     ready_i,
    input spi_flash_pkg::word_t     rdata_i,
    input spi_flash_pkg::word_t     cfg_rdata_i,
    input logic                     flash_csb_i,
    input logic                     flash_clk_i,
    input logic                     byte_valid_i,
    input logic                     byte_ready_i,
    input spi_flash_pkg::byte_t     byte_data_i,
    input spi_flash_pkg::byte_tag_t byte_tag_i,
    input logic                     jump_i,
    input logic                     soft_restart_i
);
    import spi_flash_pkg::*;

    logic cfg_en;
    int   fail_count = 0;    // read by the testbench at the end

    assign cfg_en = cfg_rdata_i[CFG_EN_BIT];

    ready_data_known: assert property (@(posedge clk) disable iff (!resetn)
        ready_i |-> !$isunknown(rdata_i))
        else begin
            fail_count = fail_count + 1;
            $error("ready_o high while rdata_o is unknown");
        end

    sck_quiet_when_deselected: assert property (@(posedge clk) disable iff (!resetn)
        (flash_csb_i && $past(flash_csb_i) && cfg_en) |-> $stable(flash_clk_i))
        else begin
            fail_count = fail_count + 1;
            $error("flash_clk_o toggled while chip select was high");
        end

    byte_valid_held: assert property (@(posedge clk) disable iff (!resetn)
        (byte_valid_i && !byte_ready_i && !jump_i && !soft_restart_i)
            |=> (byte_valid_i && $stable(byte_data_i) && $stable(byte_tag_i)))
        else begin
            fail_count = fail_count + 1;
            $error("byte_valid dropped or byte changed before byte_ready");
        end

endmodule

//--- sim/flash_model.sv
`timescale 1ns/100ps

module flash_model (
    input  logic csb_i,
    input  logic sck_i,
    input  logic si_i,
    output logic so_o
);
    import spi_flash_pkg::*;

    byte_t       in_byte        = '0;
    int          in_bits        = 0;
    int          byte_cnt       = 0;
    byte_t       cmd            = '0;
    flash_addr_t addr           = '0;
    logic        streaming      = 1'b0;
    byte_t       out_byte       = '0;
    int          out_bits       = 0;
    logic        so_q           = 1'b0;
    int          read_count     = 0;    // 0x03 commands seen
    int          wake_count     = 0;
    flash_addr_t last_read_addr = '0;

    function automatic byte_t byte_at(flash_addr_t a);
        return a[7:0] ^ a[15:8] ^ 8'h5A;
    endfunction

    assign so_o = csb_i ? 1'b0 : so_q;    // idle output reads as zero

    always @(posedge csb_i or posedge sck_i or negedge sck_i) begin
        if (csb_i) begin
            in_bits   = 0;
            byte_cnt  = 0;
            streaming = 1'b0;
            so_q      = 1'b0;
        end else if (sck_i) begin
            in_byte = {in_byte[6:0], si_i};    // msb first on io0
            in_bits = in_bits + 1;
            if (in_bits == BITS_PER_BYTE) begin
                in_bits  = 0;
                byte_cnt = byte_cnt + 1;
                if (byte_cnt == 1) begin
                    cmd = in_byte;
                    if (cmd == CMD_WAKE) begin
                        wake_count = wake_count + 1;
                    end
                    if (cmd == CMD_READ) begin
                        read_count = read_count + 1;
                    end
                end else if (cmd == CMD_READ && byte_cnt <= 4) begin
                    addr = {addr[15:0], in_byte};
                    if (byte_cnt == 4) begin
                        last_read_addr = addr;
                        streaming      = 1'b1;
                        out_byte       = byte_at(addr);
                        out_bits       = 0;
                    end
                end
            end
        end else if (streaming) begin
            so_q     = out_byte[7];    // change on falling sck
            out_byte = {out_byte[6:0], 1'b0};
            out_bits = out_bits + 1;
            if (out_bits == BITS_PER_BYTE) begin
                out_bits = 0;
                addr     = addr + 24'd1;
                out_byte = byte_at(addr);
            end
        end
    end

endmodule

//--- verilog/spi_flash_rd.sv
`timescale 1ns/100ps

module spi_flash_rd (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       valid_i,
    input  spi_flash_pkg::flash_addr_t addr_i,
    output logic                       ready_o,
    output spi_flash_pkg::word_t       rdata_o,
    input  spi_flash_pkg::lane_t       cfg_we_i,
    input  spi_flash_pkg::word_t       cfg_wdata_i,
    output spi_flash_pkg::word_t       cfg_rdata_o,
    output logic                       flash_csb_o,
    output logic                       flash_clk_o,
    output spi_flash_pkg::lane_t       flash_oe_o,
    output spi_flash_pkg::lane_t       flash_do_o,
    input  spi_flash_pkg::lane_t       flash_di_i
);
    import spi_flash_pkg::*;

    logic      soft_restart;
    logic      xfer_restart;
    logic      byte_valid;
    logic      byte_ready;
    byte_t     byte_data;
    byte_tag_t byte_tag;
    logic      byte_rd;
    logic      rx_valid;
    byte_t     rx_data;
    byte_tag_t rx_tag;
    logic      xfer_csb;
    logic      xfer_clk;
    lane_t     xfer_oe;
    lane_t     xfer_do;
    logic      jump;
    logic      hold;

    spi_cfg_reg u_cfg_reg (
        .clk            (clk),
        .resetn         (resetn),
        .cfg_we_i       (cfg_we_i),
        .cfg_wdata_i    (cfg_wdata_i),
        .xfer_csb_i     (xfer_csb),
        .xfer_clk_i     (xfer_clk),
        .xfer_oe_i      (xfer_oe),
        .xfer_do_i      (xfer_do),
        .flash_di_i     (flash_di_i),
        .cfg_rdata_o    (cfg_rdata_o),
        .soft_restart_o (soft_restart),
        .flash_csb_o    (flash_csb_o),
        .flash_clk_o    (flash_clk_o),
        .flash_oe_o     (flash_oe_o),
        .flash_do_o     (flash_do_o)
    );

    spi_cmd_seq u_cmd_seq (
        .clk            (clk),
        .resetn         (resetn),
        .soft_restart_i (soft_restart),
        .addr_i         (addr_i),
        .valid_i        (valid_i),
        .jump_i         (jump),
        .hold_i         (hold),
        .byte_ready_i   (byte_ready),
        .rx_valid_i     (rx_valid),
        .byte_valid_o   (byte_valid),
        .byte_data_o    (byte_data),
        .byte_tag_o     (byte_tag),
        .byte_rd_o      (byte_rd),
        .xfer_restart_o (xfer_restart)
    );

    spi_byte_shifter u_byte_shifter (
        .clk            (clk),
        .resetn         (resetn),
        .xfer_restart_i (xfer_restart),
        .byte_valid_i   (byte_valid),
        .byte_data_i    (byte_data),
        .byte_tag_i     (byte_tag),
        .byte_rd_i      (byte_rd),
        .flash_di_i     (flash_di_i),
        .byte_ready_o   (byte_ready),
        .rx_valid_o     (rx_valid),
        .rx_data_o      (rx_data),
        .rx_tag_o       (rx_tag),
        .xfer_csb_o     (xfer_csb),
        .xfer_clk_o     (xfer_clk),
        .xfer_oe_o      (xfer_oe),
        .xfer_do_o      (xfer_do)
    );

    spi_word_assembler u_word_assembler (
        .clk            (clk),
        .resetn         (resetn),
        .soft_restart_i (soft_restart),
        .valid_i        (valid_i),
        .addr_i         (addr_i),
        .rx_valid_i     (rx_valid),
        .rx_data_i      (rx_data),
        .rx_tag_i       (rx_tag),
        .ready_o        (ready_o),
        .rdata_o        (rdata_o),
        .jump_o         (jump),
        .hold_o         (hold)
    );

endmodule

//--- verilog/spi_word_assembler.sv
`timescale 1ns/100ps

module spi_word_assembler (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       soft_restart_i,
    input  logic                       valid_i,
    input  spi_flash_pkg::flash_addr_t addr_i,
    input  logic                       rx_valid_i,
    input  spi_flash_pkg::byte_t       rx_data_i,
    input  spi_flash_pkg::byte_tag_t   rx_tag_i,
    output logic                       ready_o,
    output spi_flash_pkg::word_t       rdata_o,
    output logic                       jump_o,
    output logic                       hold_o
);
    import spi_flash_pkg::*;

    byte_t [2:0] lanes;      // lower three bytes of the word in flight
    flash_addr_t rd_addr;
    logic        rd_valid;
    logic        rd_inc;     // next word is sequential
    logic        load_word;

    assign load_word = rx_valid_i && (rx_tag_i == TAG_B3);
    assign ready_o   = valid_i && rd_valid && (addr_i == rd_addr);
    assign jump_o    = valid_i && rd_valid && !ready_o && (addr_i != rd_addr + WORD_STEP);

    always_ff @(posedge clk) begin
        if (rx_valid_i) begin
            case (rx_tag_i)
                TAG_B0:  lanes[0] <= rx_data_i;
                TAG_B1:  lanes[1] <= rx_data_i;
                TAG_B2:  lanes[2] <= rx_data_i;
                TAG_B3:  rdata_o  <= {rx_data_i, lanes};
                default: ;
            endcase
        end
        if (load_word) begin
            rd_addr <= rd_inc ? rd_addr + WORD_STEP : addr_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn || soft_restart_i) begin
            rd_valid <= 1'b0;
            rd_inc   <= 1'b0;
            hold_o   <= 1'b0;
        end else begin
            if (load_word) begin
                rd_valid <= 1'b1;
                rd_inc   <= 1'b1;
                hold_o   <= rd_inc;    // prefetched, not asked for yet
            end
            if (valid_i) begin
                hold_o <= 1'b0;
            end
            if (jump_o) begin
                rd_valid <= 1'b0;
                rd_inc   <= 1'b0;
                hold_o   <= 1'b0;
            end
        end
    end

endmodule

//--- verilog/spi_byte_shifter.sv
`timescale 1ns/100ps

module spi_byte_shifter (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     xfer_restart_i,
    input  logic                     byte_valid_i,
    input  spi_flash_pkg::byte_t     byte_data_i,
    input  spi_flash_pkg::byte_tag_t byte_tag_i,
    input  logic                     byte_rd_i,
    input  spi_flash_pkg::lane_t     flash_di_i,
    output logic                     byte_ready_o,
    output logic                     rx_valid_o,
    output spi_flash_pkg::byte_t     rx_data_o,
    output spi_flash_pkg::byte_tag_t rx_tag_o,
    output logic                     xfer_csb_o,
    output logic                     xfer_clk_o,
    output spi_flash_pkg::lane_t     xfer_oe_o,
    output spi_flash_pkg::lane_t     xfer_do_o
);
    import spi_flash_pkg::*;

    localparam int CNT_W = $clog2(BITS_PER_BYTE + 1);

    logic [CNT_W-1:0] bit_cnt;
    byte_t            obuf;
    byte_t            ibuf;
    byte_tag_t        cur_tag;
    logic             cur_rd;
    logic             rx_q;
    logic             last_bit;
    logic             take;

    assign last_bit     = (bit_cnt == CNT_W'(1)) && xfer_clk_o;    // final falling edge
    assign byte_ready_o = ((bit_cnt == '0) || last_bit) && !xfer_restart_i;
    assign take         = byte_valid_i && byte_ready_o;
    assign rx_valid_o   = rx_q && !xfer_restart_i;    // drop bytes of a flushed transfer
    assign rx_data_o    = ibuf;
    assign xfer_oe_o    = {3'b000, !xfer_csb_o && !cur_rd};
    assign xfer_do_o    = {3'b000, obuf[BITS_PER_BYTE-1]};

    always_ff @(posedge clk) begin
        if (!resetn || xfer_restart_i) begin
            bit_cnt    <= '0;
            xfer_csb_o <= 1'b1;
            xfer_clk_o <= 1'b0;
            cur_rd     <= 1'b0;
            rx_q       <= 1'b0;
        end else begin
            rx_q <= last_bit;
            if (bit_cnt != '0) begin
                xfer_clk_o <= !xfer_clk_o;
                if (xfer_clk_o) begin
                    bit_cnt <= bit_cnt - 1'b1;
                end
            end
            if (take) begin
                bit_cnt    <= CNT_W'(BITS_PER_BYTE);
                xfer_csb_o <= 1'b0;    // stays low until restart
                xfer_clk_o <= 1'b0;
                cur_rd     <= byte_rd_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            obuf    <= byte_data_i;
            cur_tag <= byte_tag_i;
        end else if (bit_cnt != '0 && xfer_clk_o) begin
            obuf <= {obuf[BITS_PER_BYTE-2:0], 1'b0};    // msb first
        end
        if (bit_cnt != '0 && !xfer_clk_o) begin
            ibuf <= {ibuf[BITS_PER_BYTE-2:0], flash_di_i[1]};    // sample io1 on rise
        end
        if (last_bit) begin
            rx_tag_o <= cur_tag;
        end
    end

endmodule

//--- verilog/spi_cmd_seq.sv
`timescale 1ns/100ps

module spi_cmd_seq (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       soft_restart_i,
    input  spi_flash_pkg::flash_addr_t addr_i,
    input  logic                       valid_i,
    input  logic                       jump_i,
    input  logic                       hold_i,
    input  logic                       byte_ready_i,
    input  logic                       rx_valid_i,
    output logic                       byte_valid_o,
    output spi_flash_pkg::byte_t       byte_data_o,
    output spi_flash_pkg::byte_tag_t   byte_tag_o,
    output logic                       byte_rd_o,
    output logic                       xfer_restart_o
);
    import spi_flash_pkg::*;

    typedef enum logic [3:0] {
        S_RELEASE,
        S_REL_WAIT,
        S_WAKE,
        S_WAKE_WAIT,
        S_CMD,
        S_ADDR_HI,
        S_ADDR_MID,
        S_ADDR_LO,
        S_DATA
    } seq_state_t;

    seq_state_t state;
    logic [1:0] slot;       // data byte within the word
    logic       pend;       // offered but not yet taken
    logic       want;
    logic       fire;

    always_comb begin
        want        = 1'b0;
        byte_data_o = 8'h00;
        byte_tag_o  = TAG_NONE;
        case (state)
            S_RELEASE: begin
                want        = 1'b1;
                byte_data_o = CMD_RELEASE;
            end
            S_WAKE: begin
                want        = 1'b1;
                byte_data_o = CMD_WAKE;
            end
            S_CMD: begin
                want        = 1'b1;
                byte_data_o = CMD_READ;
            end
            S_ADDR_HI: begin
                want        = valid_i;    // wait for a host request
                byte_data_o = addr_i[23:16];
            end
            S_ADDR_MID: begin
                want        = 1'b1;
                byte_data_o = addr_i[15:8];
            end
            S_ADDR_LO: begin
                want        = 1'b1;
                byte_data_o = addr_i[7:0];
            end
            S_DATA: begin
                want       = !hold_i;    // stall while a prefetched word waits
                byte_tag_o = TAG_B0 + {1'b0, slot};
            end
            default: ;
        endcase
    end

    assign byte_valid_o = pend || want;
    assign byte_rd_o    = (state == S_DATA);
    assign fire         = byte_valid_o && byte_ready_i;

    always_ff @(posedge clk) begin
        xfer_restart_o <= 1'b0;
        if (!resetn || soft_restart_i) begin
            state          <= S_RELEASE;
            slot           <= 2'd0;
            pend           <= 1'b0;
            xfer_restart_o <= 1'b1;
        end else if (jump_i) begin
            state          <= S_CMD;    // new read command, wake-up not repeated
            slot           <= 2'd0;
            pend           <= 1'b0;
            xfer_restart_o <= 1'b1;
        end else begin
            pend <= byte_valid_o && !byte_ready_i;
            case (state)
                S_REL_WAIT: begin
                    if (rx_valid_i) begin
                        state          <= S_WAKE;
                        xfer_restart_o <= 1'b1;    // csb high between commands
                    end
                end
                S_WAKE_WAIT: begin
                    if (rx_valid_i) begin
                        state          <= S_CMD;
                        xfer_restart_o <= 1'b1;
                    end
                end
                default: begin
                    if (fire) begin
                        case (state)
                            S_RELEASE:  state <= S_REL_WAIT;
                            S_WAKE:     state <= S_WAKE_WAIT;
                            S_CMD:      state <= S_ADDR_HI;
                            S_ADDR_HI:  state <= S_ADDR_MID;
                            S_ADDR_MID: state <= S_ADDR_LO;
                            S_ADDR_LO:  state <= S_DATA;
                            default:    slot  <= slot + 2'd1;    // wraps to next word
                        endcase
                    end
                end
            endcase
        end
    end

endmodule

//--- verilog/spi_cfg_reg.sv
`timescale 1ns/100ps

module spi_cfg_reg (
    input  logic                 clk,
    input  logic                 resetn,
    input  spi_flash_pkg::lane_t cfg_we_i,
    input  spi_flash_pkg::word_t cfg_wdata_i,
    input  logic                 xfer_csb_i,
    input  logic                 xfer_clk_i,
    input  spi_flash_pkg::lane_t xfer_oe_i,
    input  spi_flash_pkg::lane_t xfer_do_i,
    input  spi_flash_pkg::lane_t flash_di_i,
    output spi_flash_pkg::word_t cfg_rdata_o,
    output logic                 soft_restart_o,
    output logic                 flash_csb_o,
    output logic                 flash_clk_o,
    output spi_flash_pkg::lane_t flash_oe_o,
    output spi_flash_pkg::lane_t flash_do_o
);
    import spi_flash_pkg::*;

    logic  cfg_en;
    logic  cfg_csb;
    logic  cfg_clk;
    lane_t cfg_oe;
    lane_t cfg_do;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            soft_restart_o <= 1'b1;
            cfg_en         <= CFG_RESET[CFG_EN_BIT];
            cfg_oe         <= CFG_RESET[CFG_OE_LSB +: 4];
            cfg_csb        <= CFG_RESET[CFG_CSB_BIT];
            cfg_clk        <= CFG_RESET[CFG_CLK_BIT];
            cfg_do         <= CFG_RESET[CFG_DO_LSB +: 4];
        end else begin
            soft_restart_o <= !cfg_en || (cfg_we_i != '0);    // any lane write restarts
            if (cfg_we_i[0]) begin
                cfg_csb <= cfg_wdata_i[CFG_CSB_BIT];
                cfg_clk <= cfg_wdata_i[CFG_CLK_BIT];
                cfg_do  <= cfg_wdata_i[CFG_DO_LSB +: 4];
            end
            if (cfg_we_i[1]) begin
                cfg_oe <= cfg_wdata_i[CFG_OE_LSB +: 4];
            end
            if (cfg_we_i[3]) begin
                cfg_en <= cfg_wdata_i[CFG_EN_BIT];
            end
        end
    end

    // enable low hands the pins to software
    assign flash_csb_o = cfg_en ? xfer_csb_i : cfg_csb;
    assign flash_clk_o = cfg_en ? xfer_clk_i : cfg_clk;
    assign flash_oe_o  = cfg_en ? xfer_oe_i  : cfg_oe;
    assign flash_do_o  = cfg_en ? xfer_do_i  : cfg_do;

    always_comb begin
        cfg_rdata_o = '0;    // lane 2 fields read as zero
        cfg_rdata_o[CFG_EN_BIT]      = cfg_en;
        cfg_rdata_o[CFG_OE_LSB +: 4] = flash_oe_o;
        cfg_rdata_o[CFG_CSB_BIT]     = flash_csb_o;
        cfg_rdata_o[CFG_CLK_BIT]     = flash_clk_o;
        cfg_rdata_o[CFG_DO_LSB +: 4] = flash_di_i;    // live pin inputs
    end

endmodule

//--- verilog/spi_flash_pkg.sv
package spi_flash_pkg;

    typedef logic [23:0] flash_addr_t;
    typedef logic [31:0] word_t;
    typedef logic [7:0]  byte_t;
    typedef logic [2:0]  byte_tag_t;
    typedef logic [3:0]  lane_t;    // one bit per io pin

    localparam byte_tag_t TAG_NONE = 3'd0;    // command or address byte
    localparam byte_tag_t TAG_B0   = 3'd1;
    localparam byte_tag_t TAG_B1   = 3'd2;
    localparam byte_tag_t TAG_B2   = 3'd3;
    localparam byte_tag_t TAG_B3   = 3'd4;

    localparam byte_t CMD_RELEASE = 8'hFF;
    localparam byte_t CMD_WAKE    = 8'hAB;    // release from deep power-down
    localparam byte_t CMD_READ    = 8'h03;

    localparam int CFG_EN_BIT  = 31;
    localparam int CFG_OE_LSB  = 8;
    localparam int CFG_CSB_BIT = 5;
    localparam int CFG_CLK_BIT = 4;
    localparam int CFG_DO_LSB  = 0;

    localparam word_t CFG_RESET = word_t'(1) << CFG_EN_BIT;

    localparam flash_addr_t WORD_STEP = 24'd4;
    localparam int BITS_PER_BYTE = 8;

endpackage
